// File: hw/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and register index widths
`define XLEN 32
`define REG_AW 5

`define RESET_PC 32'hbfc00000  // boot rom

// sram-like transfer size code, words only
`define SIZE_WORD 2'd2

`endif

// File: hw/mips_pkg.sv
`default_nettype none
`include "mips_consts.svh"

package mips_pkg;

    // primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_BEQ  = 6'h04, OP_BNE  = 6'h05, OP_ADDIU = 6'h09,
        OP_SLTI    = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c, OP_ORI  = 6'h0d,
        OP_XORI    = 6'h0e, OP_LUI  = 6'h0f, OP_LW   = 6'h23, OP_SW    = 6'h2b
    } op_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_ADDU = 6'h21,
        FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR  = 6'h25, FN_XOR  = 6'h26,
        FN_NOR  = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} br_op_e;
    typedef enum logic [1:0] {F_IDLE, F_WAIT_ADDR, F_WAIT_DATA} fetch_state_e;
    typedef enum logic [1:0] {R_IDLE, R_WAIT_ADDR, R_WAIT_DATA} res_state_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fd_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        alu_op_e            alu_op;
        mem_op_e            mem_op;
        br_op_e             br_op;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;        // immediate or rt
        logic [`XLEN-1:0]   store_data;
        logic [`REG_AW-1:0] rd;
        logic               reg_write;
        logic [15:0]        br_off;
    } de_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        mem_op_e            mem_op;
        logic [`XLEN-1:0]   result;      // alu value or memory address
        logic [`XLEN-1:0]   store_data;
        logic [`REG_AW-1:0] rd;
        logic               reg_write;
    } er_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] idx;
        logic [`XLEN-1:0]   value;
        logic               is_load;
    } bypass_t;

    typedef struct packed {
        logic             req;
        logic             wr;
        logic [1:0]       size;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic             addr_ok;
        logic             data_ok;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module regfile import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  bypass_t            wb_i,
    input  logic [`REG_AW-1:0] raddr1_i,
    input  logic [`REG_AW-1:0] raddr2_i,
    output logic [`XLEN-1:0]   rdata1_o,
    output logic [`XLEN-1:0]   rdata2_o
);

    logic [`XLEN-1:0] regs [32];

    // write-through so a retiring value is seen in the same cycle
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.we && wb_i.idx == addr) begin
            return wb_i.value;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.idx != '0) begin
            regs[wb_i.idx] <= wb_i.value;
        end
    end

endmodule

`default_nettype wire

// File: hw/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module inst_fetch import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    output mem_req_t         inst_req_o,
    input  mem_rsp_t         inst_rsp_i,
    output fd_t              fd_o
);

    fetch_state_e     state_q;
    logic [`XLEN-1:0] pc_q;       // next address to fetch
    logic [`XLEN-1:0] req_pc_q;   // address of the open request
    logic             discard_q;  // open request is on a squashed path
    logic             issue;
    logic             data_in;

    // start only when the fd slot is empty or decode takes it now
    assign issue   = state_q == F_IDLE && (!fd_o.valid || !hold_i) && !redirect_i;
    assign data_in = state_q == F_WAIT_DATA && inst_rsp_i.data_ok;

    assign inst_req_o.req   = state_q == F_WAIT_ADDR;
    assign inst_req_o.wr    = 1'b0;
    assign inst_req_o.size  = `SIZE_WORD;
    assign inst_req_o.addr  = req_pc_q;
    assign inst_req_o.wdata = '0;

    always_ff @(posedge clk) begin
        case (state_q)
            F_IDLE:      if (issue) state_q <= F_WAIT_ADDR;
            F_WAIT_ADDR: if (inst_rsp_i.addr_ok) state_q <= F_WAIT_DATA;
            F_WAIT_DATA: if (inst_rsp_i.data_ok) state_q <= F_IDLE;
            default:     state_q <= F_IDLE;
        endcase

        if (issue) begin
            req_pc_q <= pc_q;
            pc_q     <= pc_q + 32'd4;
        end
        if (redirect_i) begin
            pc_q      <= redirect_pc_i;
            discard_q <= state_q == F_WAIT_ADDR || (state_q == F_WAIT_DATA && !inst_rsp_i.data_ok);
        end else if (data_in) begin
            discard_q <= 1'b0;
        end

        if (redirect_i) begin
            fd_o.valid <= 1'b0;
        end else if (data_in && !discard_q) begin
            fd_o <= '{valid: 1'b1, pc: req_pc_q, instr: inst_rsp_i.rdata};
        end else if (!hold_i) begin
            fd_o.valid <= 1'b0;  // taken by decode
        end

        if (rst) begin
            state_q    <= F_IDLE;
            pc_q       <= `RESET_PC;
            discard_q  <= 1'b0;
            fd_o.valid <= 1'b0;
        end
    end

    // sram-like rule: a pending request stays put until accepted
    assert property (@(posedge clk) disable iff (rst)
        inst_req_o.req && !inst_rsp_i.addr_ok |=> $stable(inst_req_o));

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module decode import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  fd_t     fd_i,
    input  bypass_t ex_byp_i,
    input  bypass_t res_byp_i,
    input  bypass_t wb_i,
    input  logic    res_busy_i,
    input  logic    redirect_i,
    output logic    dec_stall_o,
    output de_t     de_o
);

    op_e                op;
    funct_e             funct;
    logic [`REG_AW-1:0] rs, rt, dst;
    logic [`XLEN-1:0]   rf_a, rf_b, imm_ext;
    logic               use_imm, use_shamt, sign_ext, wr;
    alu_op_e            alu_op;
    mem_op_e            mem_op;
    br_op_e             br_op;
    de_t                de_d;

    regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .wb_i     (wb_i),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (rf_a),
        .rdata2_o (rf_b)
    );

    // youngest producer wins
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] idx,
                                              input logic [`XLEN-1:0] rf_val);
        if (ex_byp_i.we && ex_byp_i.idx == idx) begin
            return ex_byp_i.value;
        end
        if (res_byp_i.we && res_byp_i.idx == idx) begin
            return res_byp_i.value;
        end
        return rf_val;
    endfunction

    assign op      = op_e'(fd_i.instr[31:26]);
    assign funct   = funct_e'(fd_i.instr[5:0]);
    assign rs      = fd_i.instr[25:21];
    assign rt      = fd_i.instr[20:16];
    assign imm_ext = sign_ext ? {{16{fd_i.instr[15]}}, fd_i.instr[15:0]}
                              : {16'h0, fd_i.instr[15:0]};

    always_comb begin
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        br_op     = BR_NONE;
        use_imm   = 1'b1;
        use_shamt = 1'b0;
        sign_ext  = 1'b1;
        dst       = rt;
        wr        = 1'b1;
        case (op)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dst     = fd_i.instr[15:11];
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: begin
                        alu_op    = ALU_SLL;
                        use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op    = ALU_SRL;
                        use_shamt = 1'b1;
                    end
                    FN_SRA: begin
                        alu_op    = ALU_SRA;
                        use_shamt = 1'b1;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                sign_ext = 1'b0;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                sign_ext = 1'b0;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                sign_ext = 1'b0;
            end
            OP_LUI:   alu_op = ALU_LUI;
            OP_LW:    mem_op = MEM_LOAD;
            OP_SW: begin
                mem_op = MEM_STORE;
                wr     = 1'b0;
            end
            OP_BEQ: begin
                br_op   = BR_BEQ;
                use_imm = 1'b0;
                wr      = 1'b0;
            end
            OP_BNE: begin
                br_op   = BR_BNE;
                use_imm = 1'b0;
                wr      = 1'b0;
            end
            default:  wr = 1'b0;
        endcase
    end

    // load in execute feeding us, wait one cycle
    assign dec_stall_o = fd_i.valid && ex_byp_i.we && ex_byp_i.is_load
                         && (ex_byp_i.idx == rs || ex_byp_i.idx == rt);

    always_comb begin
        de_d.valid      = fd_i.valid && !dec_stall_o && !redirect_i;
        de_d.pc         = fd_i.pc;
        de_d.alu_op     = alu_op;
        de_d.mem_op     = mem_op;
        de_d.br_op      = br_op;
        de_d.op_a       = use_shamt ? {27'h0, fd_i.instr[10:6]} : pick(rs, rf_a);
        de_d.op_b       = use_imm ? imm_ext : pick(rt, rf_b);
        de_d.store_data = pick(rt, rf_b);
        de_d.rd         = dst;
        de_d.reg_write  = wr && dst != '0;
        de_d.br_off     = fd_i.instr[15:0];
    end

    always_ff @(posedge clk) begin
        if (!res_busy_i) begin
            de_o <= de_d;
        end
        if (rst) begin
            de_o.valid <= 1'b0;
        end
    end

    // r0 never reaches the bypass network or the register file
    assert property (@(posedge clk) disable iff (rst)
        de_o.valid && de_o.reg_write |-> de_o.rd != '0);

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module execute import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  de_t              de_i,
    input  logic             res_busy_i,
    output logic             redirect_o,
    output logic [`XLEN-1:0] redirect_pc_o,
    output bypass_t          ex_byp_o,
    output er_t              er_o
);

    logic [`XLEN-1:0] a, b, alu_res;
    logic             taken;
    er_t              er_d;

    assign a = de_i.op_a;
    assign b = de_i.op_b;

    always_comb begin
        case (de_i.alu_op)
            ALU_ADD:  alu_res = a + b;  // also load/store address
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_NOR:  alu_res = ~(a | b);
            ALU_SLT:  alu_res = {31'h0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {31'h0, a < b};
            ALU_SLL:  alu_res = b << a[4:0];
            ALU_SRL:  alu_res = b >> a[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(b) >>> a[4:0]);
            ALU_LUI:  alu_res = {b[15:0], 16'h0};
            default:  alu_res = a + b;
        endcase
    end

    always_comb begin
        case (de_i.br_op)
            BR_BEQ:  taken = de_i.valid && a == b;
            BR_BNE:  taken = de_i.valid && a != b;
            default: taken = 1'b0;
        endcase
    end

    // no delay slot, target is relative to the branch itself plus 4
    assign redirect_o    = taken && !res_busy_i;
    assign redirect_pc_o = de_i.pc + 32'd4 + {{14{de_i.br_off[15]}}, de_i.br_off, 2'b00};

    assign ex_byp_o.we      = de_i.valid && de_i.reg_write;
    assign ex_byp_o.idx     = de_i.rd;
    assign ex_byp_o.value   = alu_res;
    assign ex_byp_o.is_load = de_i.mem_op == MEM_LOAD;

    always_comb begin
        er_d.valid      = de_i.valid && !taken;
        er_d.pc         = de_i.pc;
        er_d.mem_op     = de_i.mem_op;
        er_d.result     = alu_res;
        er_d.store_data = de_i.store_data;
        er_d.rd         = de_i.rd;
        er_d.reg_write  = de_i.reg_write;
    end

    always_ff @(posedge clk) begin
        if (!res_busy_i) begin
            er_o <= er_d;
        end
        if (rst) begin
            er_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/result.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module result import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  er_t                er_i,
    output mem_req_t           data_req_o,
    input  mem_rsp_t           data_rsp_i,
    output logic               res_busy_o,
    output bypass_t            res_byp_o,
    output bypass_t            wb_o,
    output logic [`XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]         debug_wb_rf_wen_o,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]   debug_wb_rf_wdata_o
);

    res_state_e       state_q;
    logic             is_mem;
    logic             is_load;
    logic             retire;
    logic [`XLEN-1:0] value;
    bypass_t          wb_q;
    logic [`XLEN-1:0] wb_pc_q;

    assign is_mem     = er_i.valid && er_i.mem_op != MEM_NONE;
    assign is_load    = er_i.mem_op == MEM_LOAD;
    assign retire     = er_i.valid
                        && (!is_mem || (state_q == R_WAIT_DATA && data_rsp_i.data_ok));
    assign res_busy_o = is_mem && !retire;  // freezes the whole pipe
    assign value      = is_load ? data_rsp_i.rdata : er_i.result;

    assign data_req_o.req   = is_mem && state_q != R_WAIT_DATA;
    assign data_req_o.wr    = er_i.mem_op == MEM_STORE;
    assign data_req_o.size  = `SIZE_WORD;
    assign data_req_o.addr  = er_i.result;
    assign data_req_o.wdata = er_i.store_data;

    // loaded word only matters on the data_ok cycle, the pipe is frozen before
    assign res_byp_o.we      = er_i.valid && er_i.reg_write;
    assign res_byp_o.idx     = er_i.rd;
    assign res_byp_o.value   = value;
    assign res_byp_o.is_load = is_load;

    always_ff @(posedge clk) begin
        case (state_q)
            R_IDLE: begin
                if (data_req_o.req) begin
                    state_q <= data_rsp_i.addr_ok ? R_WAIT_DATA : R_WAIT_ADDR;
                end
            end
            R_WAIT_ADDR: if (data_rsp_i.addr_ok) state_q <= R_WAIT_DATA;
            R_WAIT_DATA: if (data_rsp_i.data_ok) state_q <= R_IDLE;
            default:     state_q <= R_IDLE;
        endcase

        wb_q.we <= retire && er_i.reg_write;
        if (retire) begin
            wb_q.idx     <= er_i.rd;
            wb_q.value   <= value;
            wb_q.is_load <= is_load;
            wb_pc_q      <= er_i.pc;
        end

        if (rst) begin
            state_q <= R_IDLE;
            wb_q.we <= 1'b0;
        end
    end

    assign wb_o                = wb_q;
    assign debug_wb_pc_o       = wb_pc_q;
    assign debug_wb_rf_wen_o   = {4{wb_q.we}};
    assign debug_wb_rf_wnum_o  = wb_q.idx;
    assign debug_wb_rf_wdata_o = wb_q.value;

    // address comes from the execute adder, words only
    assert property (@(posedge clk) disable iff (rst)
        data_req_o.req |-> data_req_o.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/mips_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module mips_core import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output mem_req_t           inst_req_o,
    input  mem_rsp_t           inst_rsp_i,
    output mem_req_t           data_req_o,
    input  mem_rsp_t           data_rsp_i,
    output logic [`XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]         debug_wb_rf_wen_o,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]   debug_wb_rf_wdata_o
);

    fd_t              fd;
    de_t              de;
    er_t              er;
    bypass_t          ex_byp, res_byp, wb;
    logic             res_busy, dec_stall, hold;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    assign hold = res_busy | dec_stall;

    inst_fetch inst_fetch_i (
        .clk           (clk),
        .rst           (rst),
        .hold_i        (hold),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_req_o    (inst_req_o),
        .inst_rsp_i    (inst_rsp_i),
        .fd_o          (fd)
    );

    decode decode_i (
        .clk         (clk),
        .rst         (rst),
        .fd_i        (fd),
        .ex_byp_i    (ex_byp),
        .res_byp_i   (res_byp),
        .wb_i        (wb),
        .res_busy_i  (res_busy),
        .redirect_i  (redirect),
        .dec_stall_o (dec_stall),
        .de_o        (de)
    );

    execute execute_i (
        .clk           (clk),
        .rst           (rst),
        .de_i          (de),
        .res_busy_i    (res_busy),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_byp_o      (ex_byp),
        .er_o          (er)
    );

    result result_i (
        .clk                 (clk),
        .rst                 (rst),
        .er_i                (er),
        .data_req_o          (data_req_o),
        .data_rsp_i          (data_rsp_i),
        .res_busy_o          (res_busy),
        .res_byp_o           (res_byp),
        .wb_o                (wb),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

`default_nettype wire

// File: bench/sram_port_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module sram_port_model import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] delay_i,   // extra wait cycles for the next phase
    input  mem_req_t   req_i,
    output mem_rsp_t   rsp_o
);

    logic [`XLEN-1:0] mem [256];
    logic [7:0]       idx_q;
    logic [1:0]       wait_q;
    logic             busy_q;     // address taken, data not returned yet

    initial rsp_o = '0;

    // addr_ok and data_ok are registered, each one pulse per transaction
    always @(posedge clk) begin
        rsp_o.addr_ok <= 1'b0;
        rsp_o.data_ok <= 1'b0;
        if (rst) begin
            busy_q <= 1'b0;
            wait_q <= 2'd0;
        end else if (rsp_o.addr_ok && req_i.req) begin
            idx_q  <= req_i.addr[9:2];
            busy_q <= 1'b1;
            wait_q <= delay_i;
            if (req_i.wr) begin
                mem[req_i.addr[9:2]] <= req_i.wdata;
            end
        end else if (busy_q) begin
            if (wait_q == 2'd0) begin
                rsp_o.data_ok <= 1'b1;
                rsp_o.rdata   <= mem[idx_q];
                busy_q        <= 1'b0;
                wait_q        <= delay_i;  // address delay of the next request
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end else if (req_i.req) begin
            if (wait_q == 2'd0) begin
                rsp_o.addr_ok <= 1'b1;
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module tb_mips_core import mips_pkg::*; ();

    localparam int prog_len = 200;
    localparam logic [31:0] final_pc = `RESET_PC + 32'(4 * (prog_len - 1));
    localparam logic [5:0] reg_functs [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                              FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [5:0] shift_functs [3] = '{FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] imm_ops [6] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } wb_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_entry_t;

    logic        clk, rst;
    mem_req_t    inst_req, data_req;
    mem_rsp_t    inst_rsp, data_rsp;
    logic [31:0] wb_pc, wb_data;
    logic [3:0]  wb_wen;
    logic [4:0]  wb_num;
    logic [1:0]  imem_delay, dmem_delay;

    logic [31:0]  prog [prog_len];
    logic [31:0]  rnd_q, rnd_bits;
    wb_entry_t    exp_wb [$];
    store_entry_t exp_st [$];
    int           errors, wb_count, st_count, final_hits;
    logic         fetch_seen, inst_pend, data_pend;
    mem_req_t     inst_prev, data_prev;

    mips_core mips_core_i (
        .clk                 (clk),
        .rst                 (rst),
        .inst_req_o          (inst_req),
        .inst_rsp_i          (inst_rsp),
        .data_req_o          (data_req),
        .data_rsp_i          (data_rsp),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_num),
        .debug_wb_rf_wdata_o (wb_data)
    );

    sram_port_model inst_mem_i (
        .clk     (clk),
        .rst     (rst),
        .delay_i (imem_delay),
        .req_i   (inst_req),
        .rsp_o   (inst_rsp)
    );

    sram_port_model data_mem_i (
        .clk     (clk),
        .rst     (rst),
        .delay_i (dmem_delay),
        .req_i   (data_req),
        .rsp_o   (data_rsp)
    );

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rnd_q;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rnd_q = x;
        return x;
    endfunction

    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        return 5'd1 + 5'(r % 32'd7);  // r1..r7 only
    endfunction

    function automatic logic [31:0] fill_word(input int widx);
        return (32'(widx) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    // value written to the destination by an ALU or immediate instruction
    function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [4:0]  sa;
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0, ins[15:0]};
        sa   = ins[10:6];
        case (ins[31:26])
            OP_SPECIAL: begin
                case (ins[5:0])
                    FN_ADDU: return a + b;
                    FN_SUBU: return a - b;
                    FN_AND:  return a & b;
                    FN_OR:   return a | b;
                    FN_XOR:  return a ^ b;
                    FN_NOR:  return ~(a | b);
                    FN_SLT:  return {31'h0, $signed(a) < $signed(b)};
                    FN_SLTU: return {31'h0, a < b};
                    FN_SLL:  return b << sa;
                    FN_SRL:  return b >> sa;
                    FN_SRA:  return $signed(b) >>> sa;
                    default: return 32'h0;
                endcase
            end
            OP_ADDIU: return a + simm;
            OP_SLTI:  return {31'h0, $signed(a) < $signed(simm)};
            OP_ANDI:  return a & zimm;
            OP_ORI:   return a | zimm;
            OP_XORI:  return a ^ zimm;
            OP_LUI:   return {ins[15:0], 16'h0};
            default:  return 32'h0;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r, v;
        logic [4:0]  rs, rt, rd;
        logic [5:0]  op;
        int          skip;
        int          i;
        for (i = 0; i < prog_len - 1; i++) begin
            r  = xorshift_next();
            v  = xorshift_next();
            rs = pick_reg(r);
            rt = pick_reg(r >> 8);
            rd = pick_reg(r >> 16);
            case (r[31:28])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
                    prog[i] = {6'h00, rs, rt, rd, 5'd0, reg_functs[v[2:0]]};
                4'd6:
                    prog[i] = {6'h00, 5'd0, rt, rd, v[4:0], shift_functs[v[9:8] % 2'd3]};
                4'd7, 4'd8, 4'd9: begin
                    op      = imm_ops[v[18:16] % 3'd6];
                    prog[i] = {op, op == OP_LUI ? 5'd0 : rs, rd, v[15:0]};
                end
                4'd12:
                    prog[i] = {OP_SW, 5'd0, rt, 8'h0, v[5:0], 2'b00};
                4'd13, 4'd14: begin
                    skip = 1 + int'(v[1:0]);
                    if (i + 1 + skip > prog_len - 1) begin
                        skip = prog_len - 2 - i;  // never past the final branch
                    end
                    op      = v[2] ? OP_BNE : OP_BEQ;
                    prog[i] = {op, rs, v[3] ? rs : rt, 16'(skip)};
                end
                default:
                    prog[i] = {OP_LW, 5'd0, rd, 8'h0, v[5:0], 2'b00};
            endcase
        end
        prog[prog_len - 1] = {OP_BEQ, 5'd0, 5'd0, 16'hffff};  // spins on itself
    endtask

    // ISA order, no delay slot
    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] dmem [64];
        logic [31:0] ins, a, b, addr, pc, val;
        logic [4:0]  dst;
        int          idx;
        for (idx = 0; idx < 32; idx++) begin
            regs[idx] = '0;
        end
        for (idx = 0; idx < 64; idx++) begin
            dmem[idx] = fill_word(idx);
        end
        idx = 0;
        while (idx < prog_len - 1) begin
            ins  = prog[idx];
            pc   = `RESET_PC + 32'(idx) * 32'd4;
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            addr = a + {{16{ins[15]}}, ins[15:0]};
            dst  = ins[31:26] == OP_SPECIAL ? ins[15:11] : ins[20:16];
            val  = ref_result(ins, a, b);
            case (ins[31:26])
                OP_SW: begin
                    dmem[addr[7:2]] = b;
                    exp_st.push_back('{addr: addr, data: b});
                end
                OP_BEQ, OP_BNE: begin
                    if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                        idx += int'(ins[15:0]);
                    end
                end
                default: begin
                    if (ins[31:26] == OP_LW) begin
                        val = dmem[addr[7:2]];
                    end
                    if (dst != 5'd0) begin
                        regs[dst] = val;
                        exp_wb.push_back('{pc: pc, num: dst, data: val});
                    end
                end
            endcase
            idx++;
        end
    endtask

    task automatic log_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("ERROR t=%0t %s expected %h actual %h", $time, sig, exp, act);
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic check_writeback();
        wb_entry_t e;
        if (wb_wen !== 4'hf) begin
            log_mismatch("debug_wb_rf_wen_o", 32'hf, 32'(wb_wen));
        end
        if (exp_wb.size() == 0) begin
            fail_check("register write retired with no reference write left");
        end else begin
            e = exp_wb.pop_front();
            wb_count++;
            if (wb_pc !== e.pc) begin
                log_mismatch("debug_wb_pc_o", e.pc, wb_pc);
            end
            if (wb_num !== e.num) begin
                log_mismatch("debug_wb_rf_wnum_o", 32'(e.num), 32'(wb_num));
            end
            if (wb_data !== e.data) begin
                log_mismatch("debug_wb_rf_wdata_o", e.data, wb_data);
            end
        end
    endtask

    task automatic check_store();
        store_entry_t e;
        if (exp_st.size() == 0) begin
            fail_check("store accepted with no reference store left");
        end else begin
            e = exp_st.pop_front();
            st_count++;
            if (data_req.addr !== e.addr) begin
                log_mismatch("data_req_o.addr", e.addr, data_req.addr);
            end
            if (data_req.wdata !== e.data) begin
                log_mismatch("data_req_o.wdata", e.data, data_req.wdata);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        rnd_bits = xorshift_next();
        imem_delay <= rnd_bits[1:0];
        dmem_delay <= rnd_bits[9:8];
    end

    // everything sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (rst) begin
            if (inst_req.req !== 1'b0) fail_check("instruction request raised during reset");
            if (data_req.req !== 1'b0) fail_check("data request raised during reset");
            if (wb_wen !== 4'h0) fail_check("register write shown during reset");
        end else begin
            if (inst_pend && inst_req !== inst_prev) begin
                fail_check("instruction request changed before addr_ok");
            end
            if (data_pend && data_req !== data_prev) begin
                fail_check("data request changed before addr_ok");
            end
            if (inst_req.req && !fetch_seen) begin
                fetch_seen = 1'b1;
                if (inst_req.addr !== `RESET_PC) begin
                    log_mismatch("inst_req_o.addr", `RESET_PC, inst_req.addr);
                end
            end
            if (inst_req.req && inst_rsp.addr_ok && inst_req.addr == final_pc) begin
                final_hits++;
            end
            if (wb_wen != 4'h0) begin
                check_writeback();
            end
            if (data_req.req && data_rsp.addr_ok && data_req.wr) begin
                check_store();
            end
        end
        inst_prev = inst_req;
        data_prev = data_req;
        inst_pend = !rst && inst_req.req && !inst_rsp.addr_ok;
        data_pend = !rst && data_req.req && !data_rsp.addr_ok;
    end

    initial begin
        int i;
        int k;
        int cycles;
        rst        = 1'b1;
        imem_delay = 2'd0;
        dmem_delay = 2'd0;
        errors     = 0;
        wb_count   = 0;
        st_count   = 0;
        final_hits = 0;
        fetch_seen = 1'b0;
        inst_pend  = 1'b0;
        data_pend  = 1'b0;
        rnd_q      = 32'h59235141;
        build_program();
        run_reference();
        for (k = 0; k < 256; k++) begin
            inst_mem_i.mem[k] = k < prog_len ? prog[k] : 32'h0;  // nop tail
            data_mem_i.mem[k] = fill_word(k);
        end

        for (i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        cycles = 0;
        while (final_hits < 4 && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end

        if (final_hits < 4) begin
            fail_check("timeout, the final branch was never fetched repeatedly");
        end else begin
            if (exp_wb.size() != 0) begin
                fail_check($sformatf("%0d reference register writes never retired",
                                     exp_wb.size()));
            end
            if (exp_st.size() != 0) begin
                fail_check($sformatf("%0d reference stores never reached the data port",
                                     exp_st.size()));
            end
        end
        $display("writebacks checked %0d, stores checked %0d, errors %0d",
                 wb_count, st_count, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/mips_pkg.sv
hw/regfile.sv
hw/inst_fetch.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/mips_core.sv
bench/sram_port_model.sv
bench/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/regfile.sv
      - hw/inst_fetch.sv
      - hw/decode.sv
      - hw/execute.sv
      - hw/result.sv
      - hw/mips_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/sram_port_model.sv
      - bench/tb_mips_core.sv
